/* flist.f */
+incdir+src
src/bus_pkg.sv
src/soc_map_pkg.sv
src/reset_gen.sv
src/bus_fabric.sv
src/boot_rom.sv
src/sram_mem.sv
src/debug_gate.sv
src/harness_top.sv
bench/harness_props.sv
bench/harness_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the harness testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -Wno-fatal -f flist.f \
  --top-module harness_tb -o harness_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/harness_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

/* bench/harness_tb.sv */
/*
  Harness testbench: debug gating, ROM, SRAM and error traffic against a
  reference model, and an ndmreset pulse
*/

`timescale 1ns/1ps

`include "soc_settings.svh"

module harness_tb;

  localparam int DELAY = `DEBUG_DELAY_CYCLES;
  localparam logic [`ADDR_W-1:0] ROM_LO  = `ROM_BASE;
  localparam logic [`ADDR_W-1:0] ROM_HI  = `ADDR_W'(`ROM_BASE + `ROM_LEN);
  localparam logic [`ADDR_W-1:0] SRAM_LO = `SRAM_BASE;
  localparam logic [`ADDR_W-1:0] SRAM_HI = `ADDR_W'(`SRAM_BASE + `SRAM_LEN);
  localparam int FILL_WORDS = 32;
  localparam int MIXED_OPS  = 64;
  // Reset plus each test with a few drain cycles, doubled for margin
  localparam int TIMEOUT_CYCLES = 2 * (5 + (DELAY + 4) + (`ROM_WORDS + 4)
                                  + (FILL_WORDS + MIXED_OPS + 4) + 18 + (FILL_WORDS + 8));

  logic                clk_i;
  logic                rst_ni;
  logic                req_i;
  logic                we_i;
  logic [`ADDR_W-1:0]  addr_i;
  bus_pkg::byte_en_t   be_i;
  bus_pkg::data_word_t wdata_i;
  logic                ndmreset_i;
  logic                dm_halt_req_i;
  logic                debug_en_i;
  logic                rvalid_o;
  bus_pkg::data_word_t rdata_o;
  logic                err_o;
  logic                sys_rst_no;
  logic                debug_req_o;

  logic [`DATA_W-1:0]  model_mem [`SRAM_WORDS];
  logic [31:0]         lfsr_state;
  int                  cycle;
  int                  err_count;
  int                  check_count;
  int                  test_count;
  int                  failed_tests;
  int                  errs_at_start;
  int                  exp_cyc_q [$];
  logic [`DATA_W-1:0]  exp_data_q [$];
  logic                exp_err_q [$];

  harness_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Random source and reference model
  // ----------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  // Returns {err, data} and updates the model SRAM on writes
  function automatic logic [`DATA_W:0] ref_access(input logic we,
      input logic [`ADDR_W-1:0] addr, input logic [7:0] be, input logic [`DATA_W-1:0] wdata);
    logic [`DATA_W-1:0] data;
    logic               err;
    int                 idx;
    data = '0;
    err  = 1'b0;
    if (addr >= ROM_LO && addr < ROM_HI) begin
      idx = int'((addr - ROM_LO) >> 3);
      if (we) begin
        err = 1'b1;
      end else begin
        for (int b = 0; b < 8; b++) begin
          data[b*8 +: 8] = 8'(idx * 16 + b);
        end
      end
    end else if (addr >= SRAM_LO && addr < SRAM_HI) begin
      idx = int'((addr - SRAM_LO) >> 3);
      if (we) begin
        for (int b = 0; b < 8; b++) begin
          if (be[b]) begin
            model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
      end else begin
        data = model_mem[idx];
      end
    end else begin
      err = 1'b1;
    end
    return {err, data};
  endfunction

  // ----------------------------------------
  // Checks and bus driver
  // ----------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // Called at a falling edge, returns at the next one
  task automatic bus_access(input logic we, input logic [`ADDR_W-1:0] addr,
                            input logic [7:0] be, input logic [`DATA_W-1:0] wdata);
    logic [`DATA_W:0] resp;
    resp    = ref_access(we, addr, be, wdata);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    exp_cyc_q.push_back(cycle);
    exp_err_q.push_back(resp[`DATA_W]);
    exp_data_q.push_back(resp[`DATA_W-1:0]);
    @(negedge clk_i);
  endtask

  task automatic drain_bus();
    req_i = 1'b0;
    we_i  = 1'b0;
    while (exp_cyc_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count == errs_at_start) begin
      $display("Test %s finished with no errors", name);
    end else begin
      failed_tests++;
      $display("Test %s finished with %0d errors", name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  // Response expected on the falling edge one cycle after its request
  always @(negedge clk_i) begin
    if (rvalid_o) begin
      assert (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cycle - 1) else begin
        $display("Response at %0t with no request on the cycle before", $time);
        err_count++;
      end
      if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cycle - 1) begin
        check_value("rdata_o", rdata_o, exp_data_q.pop_front());
        check_value("err_o", err_o, exp_err_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end
    end else if (exp_cyc_q.size() != 0) begin
      assert (exp_cyc_q[0] == cycle) else begin
        $display("No response at %0t to the request of cycle %0d", $time, exp_cyc_q[0]);
        err_count++;
        void'(exp_cyc_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  initial begin
    cycle = 0;
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle = cycle + 1;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycle);
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic                op_we;
    logic [4:0]          op_idx;
    logic [7:0]          op_be;
    logic [`DATA_W-1:0]  op_data;
    logic [`ADDR_W-1:0]  op_addr;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    be_i          = '0;
    wdata_i       = '0;
    ndmreset_i    = 1'b0;
    dm_halt_req_i = 1'b1;
    debug_en_i    = 1'b1;
    lfsr_state    = 32'd3;
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    failed_tests  = 0;
    errs_at_start = 0;

    // Halt request pending from power-on
    repeat (5) begin
      @(negedge clk_i);
      check_value("debug_req_o", debug_req_o, 1'b0);
    end
    rst_ni = 1'b1;
    for (int i = 1; i <= DELAY + 1; i++) begin
      @(negedge clk_i);
      check_value("debug_req_o", debug_req_o, i >= DELAY);
      if (i <= 2) begin
        check_value("sys_rst_no", sys_rst_no, i == 2);
      end
    end
    debug_en_i = 1'b0;
    @(negedge clk_i);
    check_value("debug_req_o", debug_req_o, 1'b0);
    end_test("debug_gating");

    for (int k = 0; k < `ROM_WORDS; k++) begin
      bus_access(1'b0, ROM_LO + `ADDR_W'(k * 8), 8'hff, '0);
    end
    bus_access(1'b1, ROM_LO + `ADDR_W'(8), 8'hff, 64'hdead_beef_0000_0001);
    drain_bus();
    end_test("rom_access");

    // Full words first, so every later read hits written data
    for (int i = 0; i < FILL_WORDS; i++) begin
      op_data = rand_bits(64);
      bus_access(1'b1, SRAM_LO + `ADDR_W'(i * 8), 8'hff, op_data);
    end
    for (int i = 0; i < MIXED_OPS; i++) begin
      op_we   = 1'(rand_bits(1));
      op_idx  = 5'(rand_bits(5));
      op_be   = 8'(rand_bits(8));
      op_data = rand_bits(64);
      bus_access(op_we, SRAM_LO + `ADDR_W'({op_idx, 3'b000}), op_be, op_data);
    end
    drain_bus();
    end_test("sram_random");

    bus_access(1'b0, 32'h0000_0000, 8'hff, '0);
    bus_access(1'b1, ROM_HI, 8'hff, 64'h1);
    bus_access(1'b0, SRAM_LO - 32'd8, 8'hff, '0);
    bus_access(1'b1, SRAM_HI, 8'h0f, 64'h2);
    bus_access(1'b0, 32'hffff_fff8, 8'hff, '0);
    // Random picks from 0x4000_0000 up to below the SRAM
    for (int i = 0; i < 8; i++) begin
      op_we   = 1'(rand_bits(1));
      op_addr = {2'b01, 27'(rand_bits(27)), 3'b000};
      op_data = rand_bits(64);
      bus_access(op_we, op_addr, 8'hff, op_data);
    end
    drain_bus();
    end_test("unmapped");

    ndmreset_i = 1'b1;
    #1;
    check_value("sys_rst_no", sys_rst_no, 1'b0);
    @(negedge clk_i);
    ndmreset_i = 1'b0;
    @(negedge clk_i);
    check_value("sys_rst_no", sys_rst_no, 1'b0);
    @(negedge clk_i);
    check_value("sys_rst_no", sys_rst_no, 1'b1);
    for (int i = 0; i < FILL_WORDS; i++) begin
      bus_access(1'b0, SRAM_LO + `ADDR_W'(i * 8), 8'h00, '0);
    end
    drain_bus();
    end_test("ndmreset");

    $display("Tests %0d, failed tests %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* bench/harness_props.sv */
/*
  Response strobe checks for the bus fabric, bound into every fabric instance
*/

`timescale 1ns/1ps

module harness_props (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 rvalid_i,
  input  logic                 err_i,
  input  soc_map_pkg::region_e region_i
);

  // Every request answered on the very next edge
  rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |=> rvalid_i)
    else $error("rvalid_o missing one cycle after a request");

  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !req_i |=> !rvalid_i)
    else $error("rvalid_o raised without a request");

  err_only_with_rsp: assert property (@(posedge clk_i) err_i |-> rvalid_i)
    else $error("err_o raised without rvalid_o");

  // Response registers are held clear by the system reset
  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !rvalid_i && !err_i)
    else $error("Response strobe seen during system reset");

  // An unmapped address is answered with an error
  err_on_unmapped: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && region_i == soc_map_pkg::NONE |=> err_i)
    else $error("err_o missing for a request to an unmapped address");

endmodule

bind bus_fabric harness_props props_i (
  .clk_i    ( clk_i    ),
  .rst_ni   ( rst_ni   ),
  .req_i    ( req_i    ),
  .rvalid_i ( rvalid_o ),
  .err_i    ( err_o    ),
  .region_i ( region   )
);

/* src/harness_top.sv */
/*
  Harness top: system reset, bus fabric with ROM and SRAM targets,
  and the gated debug request
*/

`timescale 1ns/1ps

`include "soc_settings.svh"

module harness_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [`ADDR_W-1:0]  addr_i,
  input  bus_pkg::byte_en_t   be_i,
  input  bus_pkg::data_word_t wdata_i,
  input  logic                ndmreset_i,
  input  logic                dm_halt_req_i,
  input  logic                debug_en_i,
  output logic                rvalid_o,
  output bus_pkg::data_word_t rdata_o,
  output logic                err_o,
  output logic                sys_rst_no,
  output logic                debug_req_o
);

  logic                            sys_rst_n;

  logic                            rom_req;
  logic [$clog2(`ROM_WORDS)-1:0]   rom_index;
  bus_pkg::data_word_t             rom_rdata;

  logic                            sram_req;
  logic                            sram_we;
  logic [$clog2(`SRAM_WORDS)-1:0]  sram_index;
  bus_pkg::byte_en_t               sram_be;
  bus_pkg::data_word_t             sram_wdata;
  bus_pkg::data_word_t             sram_rdata;

  // ----------------------------------------
  // Reset
  // ----------------------------------------
  reset_gen i_reset_gen (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  assign sys_rst_no = sys_rst_n;

  // ----------------------------------------
  // Bus and memories
  // ----------------------------------------
  bus_fabric i_bus_fabric (
    .clk_i        ( clk_i      ),
    .rst_ni       ( sys_rst_n  ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .be_i         ( be_i       ),
    .wdata_i      ( wdata_i    ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_rdata_i ( sram_rdata ),
    .rom_req_o    ( rom_req    ),
    .rom_index_o  ( rom_index  ),
    .sram_req_o   ( sram_req   ),
    .sram_we_o    ( sram_we    ),
    .sram_index_o ( sram_index ),
    .sram_be_o    ( sram_be    ),
    .sram_wdata_o ( sram_wdata ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .index_i ( rom_index ),
    .rdata_o ( rom_rdata )
  );

  sram_mem i_sram_mem (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .index_i ( sram_index ),
    .be_i    ( sram_be    ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

  // ----------------------------------------
  // Debug
  // ----------------------------------------
  // Counts from power-on reset only, not from ndmreset
  debug_gate i_debug_gate (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .dm_halt_req_i ( dm_halt_req_i ),
    .debug_en_i    ( debug_en_i    ),
    .debug_req_o   ( debug_req_o   )
  );

endmodule

/* src/debug_gate.sv */
/*
  Debug request gate: holds off halt requests for a fixed window after
  power-on reset, then passes the enabled request through
*/

`timescale 1ns/1ps

`include "soc_settings.svh"

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dm_halt_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_W = $clog2(`DEBUG_DELAY_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             window_open;

  // Lets the core run boot code before it can be halted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CNT_W'(`DEBUG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign window_open = (cnt_q == '0);
  assign debug_req_o = window_open & debug_en_i & dm_halt_req_i;

endmodule

/* src/sram_mem.sv */
/*
  Word-wide SRAM with byte-lane write enables and a registered read port
*/

`timescale 1ns/1ps

`include "soc_settings.svh"

module sram_mem (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [$clog2(`SRAM_WORDS)-1:0]  index_i,
  input  bus_pkg::byte_en_t               be_i,
  input  bus_pkg::data_word_t             wdata_i,
  output bus_pkg::data_word_t             rdata_o
);

  localparam int unsigned WORDS = `SRAM_WORDS;
  localparam int unsigned LANES = `DATA_W / 8;

  bus_pkg::data_word_t mem [WORDS];
  bus_pkg::data_word_t merged;
  bus_pkg::data_word_t rdata_q;

  // ----------------------------------------
  // Byte-lane merge
  // ----------------------------------------
  // Start from the stored word and replace only the enabled lanes
  always_comb begin
    merged = mem[index_i];
    for (int b = 0; b < LANES; b++) begin
      if (be_i[b]) begin
        merged.lanes[b] = wdata_i.lanes[b];
      end
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  // Contents survive every reset
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[index_i] <= merged;
      end else begin
        rdata_q <= mem[index_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* src/boot_rom.sv */
/*
  Boot ROM: fixed table where byte b of word k holds k*16+b, registered read
*/

`timescale 1ns/1ps

`include "soc_settings.svh"

module boot_rom (
  input  logic                           clk_i,
  input  logic                           req_i,
  input  logic [$clog2(`ROM_WORDS)-1:0]  index_i,
  output bus_pkg::data_word_t            rdata_o
);

  localparam int unsigned WORDS = `ROM_WORDS;
  localparam int unsigned LANES = `DATA_W / 8;

  bus_pkg::data_word_t rom_table [WORDS];
  bus_pkg::data_word_t rdata_q;

  // ----------------------------------------
  // Table contents
  // ----------------------------------------
  for (genvar k = 0; k < WORDS; k++) begin : gen_word
    for (genvar b = 0; b < LANES; b++) begin : gen_lane
      assign rom_table[k].lanes[b] = 8'(k * 16 + b);
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------
  // Output holds its last word between reads
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rom_table[index_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* src/bus_fabric.sv */
/*
  Single-master fabric: decodes each request to ROM, SRAM or the error target
  and returns a registered response one cycle later
*/

`timescale 1ns/1ps

`include "soc_settings.svh"

module bus_fabric (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [`ADDR_W-1:0]               addr_i,
  input  bus_pkg::byte_en_t                be_i,
  input  bus_pkg::data_word_t              wdata_i,
  input  bus_pkg::data_word_t              rom_rdata_i,
  input  bus_pkg::data_word_t              sram_rdata_i,
  output logic                             rom_req_o,
  output logic [$clog2(`ROM_WORDS)-1:0]    rom_index_o,
  output logic                             sram_req_o,
  output logic                             sram_we_o,
  output logic [$clog2(`SRAM_WORDS)-1:0]   sram_index_o,
  output bus_pkg::byte_en_t                sram_be_o,
  output bus_pkg::data_word_t              sram_wdata_o,
  output logic                             rvalid_o,
  output bus_pkg::data_word_t              rdata_o,
  output logic                             err_o
);

  localparam int unsigned OFF_W       = $clog2(`DATA_W / 8);
  localparam int unsigned ROM_IDX_W   = $clog2(`ROM_WORDS);
  localparam int unsigned SRAM_IDX_W  = $clog2(`SRAM_WORDS);
  localparam logic [`ADDR_W-1:0] ROM_BASE  = `ADDR_W'(`ROM_BASE);
  localparam logic [`ADDR_W-1:0] ROM_END   = `ADDR_W'(`ROM_BASE + `ROM_LEN);
  localparam logic [`ADDR_W-1:0] SRAM_BASE = `ADDR_W'(`SRAM_BASE);
  localparam logic [`ADDR_W-1:0] SRAM_END  = `ADDR_W'(`SRAM_BASE + `SRAM_LEN);

  soc_map_pkg::region_e region;
  soc_map_pkg::region_e src_d;
  soc_map_pkg::region_e src_q;
  logic                 err_d;
  logic                 err_q;
  logic                 rvalid_q;

  // ----------------------------------------
  // Request decode
  // ----------------------------------------
  always_comb begin
    region = soc_map_pkg::NONE;
    if (addr_i >= ROM_BASE && addr_i < ROM_END) begin
      region = soc_map_pkg::ROM;
    end else if (addr_i >= SRAM_BASE && addr_i < SRAM_END) begin
      region = soc_map_pkg::SRAM;
    end
  end

  // Word index inside the region, byte offset dropped
  assign rom_index_o  = ROM_IDX_W'((addr_i - ROM_BASE) >> OFF_W);
  assign sram_index_o = SRAM_IDX_W'((addr_i - SRAM_BASE) >> OFF_W);

  // ROM is read only, so a write never reaches it
  assign rom_req_o    = req_i & ~we_i & (region == soc_map_pkg::ROM);
  assign sram_req_o   = req_i & (region == soc_map_pkg::SRAM);
  assign sram_we_o    = we_i;
  assign sram_be_o    = be_i;
  assign sram_wdata_o = wdata_i;

  assign err_d = (region == soc_map_pkg::NONE) | (we_i & (region == soc_map_pkg::ROM));

  // Source of the returning data; writes and errors come back as zero
  assign src_d = (we_i || err_d) ? soc_map_pkg::NONE : region;

  // ----------------------------------------
  // Response stage
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      src_q    <= soc_map_pkg::NONE;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & err_d;
      src_q    <= req_i ? src_d : soc_map_pkg::NONE;
    end
  end

  always_comb begin
    case (src_q)
      soc_map_pkg::ROM:  rdata_o = rom_rdata_i;
      soc_map_pkg::SRAM: rdata_o = sram_rdata_i;
      default:           rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

/* src/reset_gen.sv */
/*
  System reset generator: merges the external reset with the debug ndmreset,
  asserts at once and releases synchronously to clk_i
*/

`timescale 1ns/1ps

`include "soc_settings.svh"

module reset_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  localparam int unsigned STAGES = `RST_SYNC_STAGES;

  logic              rst_comb_n;
  logic [STAGES-1:0] sync_q;

  // Either cause pulls the chain low without waiting for a clock
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Release shifts a one through the chain
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[STAGES-2:0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[STAGES-1];

endmodule

/* src/soc_map_pkg.sv */
/*
  Memory map types: the region a bus address decodes to
*/

`include "soc_settings.svh"

package soc_map_pkg;

  // NONE is the default target and answers with an error
  typedef enum logic [1:0] {
    ROM  = 2'd0,
    SRAM = 2'd1,
    NONE = 2'd2
  } region_e;

endpackage

/* src/bus_pkg.sv */
/*
  Bus payload types: the 64-bit data word and its byte enables
*/

`include "soc_settings.svh"

package bus_pkg;

  // Word seen whole by the fabric, lane by lane by the SRAM merge
  typedef union packed {
    logic [`DATA_W-1:0]          word;
    logic [`DATA_W/8-1:0][7:0]   lanes;
  } data_word_t;

  // One enable bit per byte lane
  typedef logic [`DATA_W/8-1:0] byte_en_t;

endpackage

/* src/soc_settings.svh */
/*
  Harness settings: bus widths, address map, memory sizes and reset/debug timing
*/

`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define ADDR_W 32
`define DATA_W 64

// ----------------------------------------
// Address map
// ----------------------------------------
// Boot ROM, 16 words of 8 bytes
`define ROM_BASE  32'h0001_0000
`define ROM_WORDS 16
`define ROM_LEN   (`ROM_WORDS * (`DATA_W / 8))

// Main SRAM
`define SRAM_BASE  32'h8000_0000
`define SRAM_WORDS 256
`define SRAM_LEN   (`SRAM_WORDS * (`DATA_W / 8))

// ----------------------------------------
// Reset and debug timing
// ----------------------------------------
`define DEBUG_DELAY_CYCLES 20
`define RST_SYNC_STAGES    2

`endif
